/* acfa_memory.f */
+incdir+.
acfa_map_pkg.sv
acfa_status_pkg.sv
acfa_meta_regs.sv
acfa_word_mem.sv
acfa_vrf_mem.sv
acfa_read_mux.sv
acfa_memory.sv
tb_acfa_memory.sv

/* tb_acfa_memory.sv */
`timescale 1ns/1ps
`include "acfa_config.svh"

module tb_acfa_memory;

    logic        mclk = 1'b0;
    logic        puc_rst;
    logic [13:0] per_addr;
    logic [15:0] per_din;
    logic        per_en;
    logic [1:0]  per_we;
    logic        cm_uart_continue, entered_tcb, boot_done;
    logic        flush_log, flush_slice, er_done;
    logic [15:0] top_slice, bottom_slice, cflow_logs_ptr_din;
    logic        rx_done;
    logic [7:0]  rx_data_out;
    logic [15:0] read_idx;
    logic [15:0] per_dout, read_val, vrfmem_write_out;
    logic [15:0] er_min, er_max, vrf_response_out, log_state_out;
    logic        vrf_resp_irq;

    // reference model state
    logic [15:0] m_chal [0:15];
    logic [15:0] m_mac  [0:15];
    logic [15:0] m_meta [0:6];     // ermin .. vrf_response
    logic [7:0]  m_vrf  [0:65];
    int          m_cnt;
    logic        m_full, m_full_q, m_irq;

    integer seed;
    int     err_cnt = 0;
    int     chk_cnt = 0;
    int     irq_cnt = 0;
    int     cyc = 0;

    acfa_memory dut0 (.*);

    always #50 mclk = ~mclk;   // 100 ns period

    // ------------------------------------------------------------
    // reference model updated on each rising edge
    // ------------------------------------------------------------
    assign m_full = boot_done && (m_cnt >= 33);

    always @(posedge mclk or posedge puc_rst)
    begin
        if (puc_rst)
        begin
            m_meta[0] <= 16'h0000;
            m_meta[1] <= 16'h0000;
            m_meta[2] <= 16'h0000;
            m_meta[3] <= `ACFA_TOP_SLICE_RST;
            m_meta[4] <= `ACFA_BOTTOM_SLICE_RST;
            m_meta[5] <= 16'h00CC;
            m_meta[6] <= 16'h00DD;
            m_cnt     <= 0;
            m_full_q  <= 1'b0;
            m_irq     <= 1'b0;
        end
        else
        begin
            if (per_en && per_we != 2'b00)
            begin
                if (per_addr >= `ACFA_CHAL_BASE && per_addr < `ACFA_CHAL_BASE + 16)
                begin
                    if (per_we[0]) m_chal[per_addr - `ACFA_CHAL_BASE][7:0]  <= per_din[7:0];
                    if (per_we[1]) m_chal[per_addr - `ACFA_CHAL_BASE][15:8] <= per_din[15:8];
                end
                if (per_addr >= `ACFA_MAC_BASE && per_addr < `ACFA_MAC_BASE + 16)
                begin
                    if (per_we[0]) m_mac[per_addr - `ACFA_MAC_BASE][7:0]  <= per_din[7:0];
                    if (per_we[1]) m_mac[per_addr - `ACFA_MAC_BASE][15:8] <= per_din[15:8];
                end
                if (per_addr == `ACFA_META_BASE)     m_meta[0] <= per_din;   // whole word
                if (per_addr == `ACFA_META_BASE + 1) m_meta[1] <= per_din;
            end
            if (entered_tcb && !cm_uart_continue)
                m_meta[2] <= cflow_logs_ptr_din;
            m_meta[3] <= top_slice;
            m_meta[4] <= bottom_slice;
            if (flush_log && flush_slice)    m_meta[5] <= 16'h0003;
            else if (flush_log)              m_meta[5] <= 16'h0002;
            else if (flush_slice || er_done) m_meta[5] <= 16'h0001;
            if (per_en && per_we != 2'b00 && per_addr == `ACFA_META_BASE + 6)
                m_meta[6] <= per_din;                     // bus write first
            else if (flush_log || flush_slice)
                m_meta[6] <= 16'h0000;
            else if (m_full)
                m_meta[6] <= 16'h0001;
            if (rx_done && m_cnt < 66)
                m_vrf[m_cnt] <= rx_data_out;
            if (flush_log || flush_slice) m_cnt <= 0;
            else if (rx_done && m_cnt < 66) m_cnt <= m_cnt + 1;
            m_full_q <= m_full;
            m_irq    <= m_full && !m_full_q;              // one cycle after the rise
        end
    end

    // expected bus read data is zero outside a read access
    function automatic logic [15:0] expect_bus(input logic [13:0] a, input logic en,
                                               input logic [1:0] we);
        int o;
        expect_bus = 16'h0000;
        if (en && we == 2'b00)
        begin
            if (a >= `ACFA_CHAL_BASE && a < `ACFA_CHAL_BASE + 16)
                expect_bus = m_chal[a - `ACFA_CHAL_BASE];
            else if (a >= `ACFA_META_BASE && a < `ACFA_META_BASE + 7)
                expect_bus = m_meta[a - `ACFA_META_BASE];
            else if (a >= `ACFA_MAC_BASE && a < `ACFA_MAC_BASE + 16)
                expect_bus = m_mac[a - `ACFA_MAC_BASE];
            else if (a >= `ACFA_VRF_BASE && a < `ACFA_VRF_BASE + 33)
            begin
                o = a - `ACFA_VRF_BASE;
                expect_bus = {m_vrf[2*o+1], m_vrf[2*o]};   // even byte low
            end
        end
    endfunction

    // report image is mac, challenge, metadata
    function automatic logic [15:0] expect_tx(input logic [15:0] idx);
        if (idx < 16)      return m_mac[idx];
        else if (idx < 32) return m_chal[idx - 16];
        else if (idx < 39) return m_meta[idx - 32];
        else               return 16'h0000;
    endfunction

    // ------------------------------------------------------------
    // compare mid cycle while everything is stable
    // ------------------------------------------------------------
    always @(negedge mclk)
    begin
        if (!puc_rst)
        begin
            chk_cnt = chk_cnt + 1;
            if (vrf_resp_irq) irq_cnt = irq_cnt + 1;
            assert (per_dout == expect_bus(per_addr, per_en, per_we))
            else
            begin
                err_cnt = err_cnt + 1;
                $display("ERROR %0t: per_dout %h, expected %h at addr %h", $time, per_dout,
                         expect_bus(per_addr, per_en, per_we), per_addr);
            end
            assert (read_val == expect_tx(read_idx))
            else
            begin
                err_cnt = err_cnt + 1;
                $display("ERROR %0t: read_val %h, expected %h at idx %0d", $time, read_val,
                         expect_tx(read_idx), read_idx);
            end
            assert (er_min == m_meta[0] && er_max == m_meta[1])
            else
            begin
                err_cnt = err_cnt + 1;
                $display("ERROR %0t: er_min/er_max %h/%h, expected %h/%h", $time, er_min,
                         er_max, m_meta[0], m_meta[1]);
            end
            assert (log_state_out == m_meta[5] && vrf_response_out == m_meta[6])
            else
            begin
                err_cnt = err_cnt + 1;
                $display("ERROR %0t: log_state/vrf_response %h/%h, expected %h/%h", $time,
                         log_state_out, vrf_response_out, m_meta[5], m_meta[6]);
            end
            assert (vrfmem_write_out == m_cnt && vrf_resp_irq == m_irq)
            else
            begin
                err_cnt = err_cnt + 1;
                $display("ERROR %0t: count/irq %0d/%b, expected %0d/%b", $time,
                         vrfmem_write_out, vrf_resp_irq, m_cnt, m_irq);
            end
        end
    end

    // the tests run about 330 cycles
    always @(posedge mclk)
    begin
        cyc = cyc + 1;
        if (cyc >= 3000)
        begin
            $display("run timed out after %0d cycles, tests did not finish", cyc);
            $display("Simulation failed");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // stimulus tasks change inputs 5 ns after the edge
    // ------------------------------------------------------------
    task automatic step();
        @(posedge mclk);
        #5;
    endtask

    task automatic bus_write(input logic [13:0] a, input logic [15:0] d, input logic [1:0] we);
        per_en   = 1'b1;
        per_we   = we;
        per_addr = a;
        per_din  = d;
        step();
        per_en = 1'b0;
        per_we = 2'b00;
    endtask

    task automatic bus_read(input logic [13:0] a);
        per_en   = 1'b1;
        per_we   = 2'b00;
        per_addr = a;
        step();   // checked mid cycle
        per_en = 1'b0;
    endtask

    task automatic send_byte(input logic [7:0] b);
        rx_done     = 1'b1;
        rx_data_out = b;
        step();
        rx_done = 1'b0;
    endtask

    initial
    begin
        int i;
        int irq_base;
        seed = 32'hc4bb;
        puc_rst = 1'b1;
        per_addr = '0;
        per_din = '0;
        per_en = 1'b0;
        per_we = 2'b00;
        cm_uart_continue = 1'b0;
        entered_tcb = 1'b0;
        boot_done = 1'b0;
        flush_log = 1'b0;
        flush_slice = 1'b0;
        er_done = 1'b0;
        top_slice = `ACFA_TOP_SLICE_RST;   // hold the reset patterns
        bottom_slice = `ACFA_BOTTOM_SLICE_RST;
        cflow_logs_ptr_din = '0;
        rx_done = 1'b0;
        rx_data_out = '0;
        read_idx = 16'd40;                 // outside the image until memories hold data
        repeat (4) @(posedge mclk);
        #5 puc_rst = 1'b0;

        // reset values then er_min and er_max
        for (i = 0; i < 7; i++) bus_read(`ACFA_META_BASE + i);
        bus_write(`ACFA_META_BASE, $random(seed), 2'b11);
        bus_write(`ACFA_META_BASE + 1, $random(seed), 2'b11);
        bus_read(`ACFA_META_BASE);
        bus_read(`ACFA_META_BASE + 1);

        // challenge and mac with full words then single bytes
        for (i = 0; i < 16; i++)
        begin
            bus_write(`ACFA_CHAL_BASE + i, $random(seed), 2'b11);
            bus_write(`ACFA_MAC_BASE + i, $random(seed), 2'b11);
        end
        for (i = 0; i < 4; i++)
        begin
            bus_write(`ACFA_CHAL_BASE + i, $random(seed), 2'b01);   // low byte only
            bus_write(`ACFA_MAC_BASE + 4 + i, $random(seed), 2'b10);
        end
        for (i = 0; i < 16; i++)
        begin
            bus_read(`ACFA_CHAL_BASE + i);
            bus_read(`ACFA_MAC_BASE + i);
        end
        for (i = 0; i < 48; i++)
        begin
            read_idx = i;   // mac, chal, meta, then past the end
            step();
        end
        read_idx = 16'hffff;
        step();

        // log pointer gating, slices, log_state priority
        for (i = 0; i < 8; i++)
        begin
            {entered_tcb, cm_uart_continue} = i[1:0];
            cflow_logs_ptr_din = $random(seed);
            read_idx = 16'd34;
            bus_read(`ACFA_META_BASE + 2);
        end
        entered_tcb = 1'b0;
        for (i = 0; i < 8; i++)
        begin
            top_slice    = $random(seed);
            bottom_slice = $random(seed);
            read_idx     = 16'd35;
            bus_read(`ACFA_META_BASE + 4);
        end
        for (i = 0; i < 8; i++)
        begin
            {flush_log, flush_slice, er_done} = i[2:0];
            step();
            {flush_log, flush_slice, er_done} = 3'b000;
            read_idx = 16'd37;
            bus_read(`ACFA_META_BASE + 5);
        end
        for (i = 32; i < 39; i++)
        begin
            read_idx = i;
            step();
        end

        // uart fill past the end stops the count at 66
        for (i = 0; i < 70; i++) send_byte($random(seed));
        assert (vrfmem_write_out == 16'd66)
        else
        begin
            err_cnt = err_cnt + 1;
            $display("ERROR %0t: byte count %0d after 70 strobes", $time, vrfmem_write_out);
        end
        for (i = 0; i < 33; i++) bus_read(`ACFA_VRF_BASE + i);

        // interrupt on the 33rd byte with boot_done
        flush_log = 1'b1;
        step();
        flush_log = 1'b0;
        boot_done = 1'b1;
        irq_base  = irq_cnt;
        read_idx  = 16'd38;
        for (i = 0; i < 33; i++) send_byte($random(seed));
        repeat (4) step();
        assert (irq_cnt - irq_base == 1)
        else
        begin
            err_cnt = err_cnt + 1;
            $display("ERROR %0t: %0d irq pulses, expected 1", $time, irq_cnt - irq_base);
        end
        bus_read(`ACFA_META_BASE + 6);
        bus_write(`ACFA_META_BASE + 6, 16'h5a5a, 2'b11);   // wins over the set
        bus_read(`ACFA_META_BASE + 6);
        flush_slice = 1'b1;
        step();
        flush_slice = 1'b0;
        bus_read(`ACFA_META_BASE + 6);
        repeat (2) step();

        $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

/* acfa_memory.sv */
`timescale 1ns/1ps
`include "acfa_config.svh"

module acfa_memory (
    input  logic        mclk,
    input  logic        puc_rst,
    // peripheral bus
    input  logic [13:0] per_addr,
    input  logic [15:0] per_din,
    input  logic        per_en,
    input  logic [1:0]  per_we,
    output logic [15:0] per_dout,
    // status inputs
    input  logic        cm_uart_continue,
    input  logic        entered_tcb,
    input  logic        boot_done,
    input  logic        flush_log,
    input  logic        flush_slice,
    input  logic        er_done,
    input  logic [15:0] top_slice,
    input  logic [15:0] bottom_slice,
    input  logic [15:0] cflow_logs_ptr_din,
    // uart receive and transmit
    input  logic        rx_done,
    input  logic [7:0]  rx_data_out,
    input  logic [15:0] read_idx,
    output logic [15:0] read_val,
    output logic [15:0] vrfmem_write_out,
    output logic        vrf_resp_irq,
    // status outputs
    output logic [15:0] er_min,
    output logic [15:0] er_max,
    output logic [15:0] vrf_response_out,
    output logic [15:0] log_state_out
);
    import acfa_map_pkg::*;

    logic [15:0] meta_rd, chal_rd, mac_rd, vrf_rd;   // bus read per region
    logic [15:0] meta_hw, chal_hw, mac_hw;           // transmit read per region
    meta_reg_e   meta_idx;
    logic [3:0]  word_idx;
    logic        full_level;

    // ------------------------------------------------------------
    // regions
    // ------------------------------------------------------------
    acfa_meta_regs meta_regs (
        .mclk, .puc_rst, .per_en, .per_addr, .per_we, .per_din,
        .entered_tcb, .cm_uart_continue, .cflow_logs_ptr_din,
        .top_slice, .bottom_slice, .flush_log, .flush_slice, .er_done,
        .full_level, .hw_idx(meta_idx), .rd_data(meta_rd), .hw_data(meta_hw),
        .er_min, .er_max, .log_state_out, .vrf_response_out
    );

    acfa_word_mem #(.base_addr(`ACFA_CHAL_BASE), .words(`ACFA_CHAL_WORDS)) chal_mem (
        .mclk, .per_en, .per_addr, .per_we, .per_din,
        .hw_idx(word_idx), .rd_data(chal_rd), .hw_data(chal_hw)
    );

    acfa_word_mem #(.base_addr(`ACFA_MAC_BASE), .words(`ACFA_MAC_WORDS)) mac_mem (
        .mclk, .per_en, .per_addr, .per_we, .per_din,
        .hw_idx(word_idx), .rd_data(mac_rd), .hw_data(mac_hw)
    );

    acfa_vrf_mem vrf_mem (
        .mclk, .puc_rst, .per_en, .per_addr, .per_we, .rx_done, .rx_data_out,
        .boot_done, .flush_log, .flush_slice, .rd_data(vrf_rd),
        .vrfmem_write_out, .full_level, .vrf_resp_irq
    );

    // bus data combine and transmit index decode
    acfa_read_mux read_mux (
        .read_idx, .meta_rd, .chal_rd, .mac_rd, .vrf_rd,
        .meta_hw, .chal_hw, .mac_hw, .per_dout, .read_val, .meta_idx, .word_idx
    );

endmodule

/* acfa_read_mux.sv */
`timescale 1ns/1ps

module acfa_read_mux (
    input  logic [15:0]             read_idx,   // word index into the report
    input  logic [15:0]             meta_rd,
    input  logic [15:0]             chal_rd,
    input  logic [15:0]             mac_rd,
    input  logic [15:0]             vrf_rd,
    input  logic [15:0]             meta_hw,
    input  logic [15:0]             chal_hw,
    input  logic [15:0]             mac_hw,
    output logic [15:0]             per_dout,
    output logic [15:0]             read_val,
    output acfa_map_pkg::meta_reg_e meta_idx,
    output logic [3:0]              word_idx   // shared by chal and mac
);
    import acfa_map_pkg::*;

    tx_region_e  region;
    logic [15:0] local_idx;

    // unselected regions drive zero, so a plain or is enough
    assign per_dout = meta_rd | chal_rd | mac_rd | vrf_rd;

    // ------------------------------------------------------------
    // report image order is mac, challenge, metadata
    // ------------------------------------------------------------
    always_comb
    begin
        region    = TX_NONE;
        local_idx = '0;
        if (read_idx < TX_CHAL_START)
        begin
            region    = TX_MAC;
            local_idx = read_idx;
        end
        else if (read_idx < TX_META_START)
        begin
            region    = TX_CHAL;
            local_idx = read_idx - TX_CHAL_START;
        end
        else if (read_idx < TX_END)
        begin
            region    = TX_META;
            local_idx = read_idx - TX_META_START;
        end
    end

    assign word_idx = local_idx[3:0];
    assign meta_idx = meta_reg_e'(local_idx[2:0]);

    always_comb
    begin
        case (region)
            TX_MAC:  read_val = mac_hw;
            TX_CHAL: read_val = chal_hw;
            TX_META: read_val = meta_hw;
            default: read_val = '0;   // beyond the image
        endcase
    end

endmodule

/* acfa_vrf_mem.sv */
`timescale 1ns/1ps
`include "acfa_config.svh"

module acfa_vrf_mem (
    input  logic        mclk,
    input  logic        puc_rst,
    input  logic        per_en,
    input  logic [13:0] per_addr,
    input  logic [1:0]  per_we,
    input  logic        rx_done,          // one byte received
    input  logic [7:0]  rx_data_out,
    input  logic        boot_done,
    input  logic        flush_log,
    input  logic        flush_slice,
    output logic [15:0] rd_data,
    output logic [15:0] vrfmem_write_out,  // bytes received so far
    output logic        full_level,
    output logic        vrf_resp_irq
);

    localparam int vrf_words = `ACFA_VRF_BYTES / 2;

    logic [7:0]  mem [0:`ACFA_VRF_BYTES-1];
    logic [15:0] byte_cnt;
    logic        rx_accept;
    logic        full_q;

    // ------------------------------------------------------------
    // uart side stores bytes in arrival order
    // ------------------------------------------------------------
    assign rx_accept = rx_done && (byte_cnt < `ACFA_VRF_BYTES);   // drop when full

    always_ff @(posedge mclk)
    begin
        if (rx_accept)
            mem[byte_cnt[6:0]] <= rx_data_out;
    end

    always_ff @(posedge mclk or posedge puc_rst)
    begin
        if (puc_rst)
            byte_cnt <= '0;
        else if (flush_log || flush_slice)
            byte_cnt <= '0;                // a new report starts over
        else if (rx_accept)
            byte_cnt <= byte_cnt + 16'd1;
    end

    assign vrfmem_write_out = byte_cnt;

    // ------------------------------------------------------------
    // bus read puts the even byte in the low half
    // ------------------------------------------------------------
    logic        vrf_sel;
    logic [13:0] vrf_off;
    logic [5:0]  vrf_word;

    assign vrf_sel  = per_en && !(|per_we) && (per_addr >= `ACFA_VRF_BASE)
                      && (per_addr < `ACFA_VRF_BASE + vrf_words);
    assign vrf_off  = per_addr - `ACFA_VRF_BASE;
    assign vrf_word = vrf_off[5:0];
    assign rd_data  = vrf_sel ? {mem[{vrf_word, 1'b1}], mem[{vrf_word, 1'b0}]} : '0;

    // ------------------------------------------------------------
    // full level and interrupt
    // ------------------------------------------------------------
    // full once half the buffer has arrived
    assign full_level = boot_done && (byte_cnt >= vrf_words);

    always_ff @(posedge mclk or posedge puc_rst)
    begin
        if (puc_rst)
        begin
            full_q       <= 1'b0;
            vrf_resp_irq <= 1'b0;
        end
        else
        begin
            full_q       <= full_level;
            vrf_resp_irq <= full_level && !full_q;   // rising edge only
        end
    end

    a_cnt_bound: assert property (@(posedge mclk) disable iff (puc_rst)
        byte_cnt <= `ACFA_VRF_BYTES);
    a_irq_single: assert property (@(posedge mclk) disable iff (puc_rst)
        vrf_resp_irq |=> !vrf_resp_irq);

endmodule

/* acfa_word_mem.sv */
`timescale 1ns/1ps

module acfa_word_mem #(
    parameter logic [13:0] base_addr = 14'h0,   // word address of the window
    parameter int          words     = 16
) (
    input  logic        mclk,
    input  logic        per_en,
    input  logic [13:0] per_addr,
    input  logic [1:0]  per_we,      // one bit per byte lane
    input  logic [15:0] per_din,
    input  logic [3:0]  hw_idx,      // transmit side index
    output logic [15:0] rd_data,
    output logic [15:0] hw_data
);

    localparam int aw = $clog2(words);

    logic [15:0]   mem [0:words-1];
    logic          mem_sel;
    logic [13:0]   mem_off;
    logic [aw-1:0] mem_idx;

    // ------------------------------------------------------------
    // window decode
    // ------------------------------------------------------------
    assign mem_sel = per_en && (per_addr >= base_addr)
                     && (per_addr < base_addr + words);
    assign mem_off = per_addr - base_addr;
    assign mem_idx = mem_off[aw-1:0];

    // byte enabled write, contents undefined until written
    always_ff @(posedge mclk)
    begin
        if (mem_sel)
        begin
            if (per_we[0])
                mem[mem_idx][7:0]  <= per_din[7:0];    // low byte
            if (per_we[1])
                mem[mem_idx][15:8] <= per_din[15:8];   // high byte
        end
    end

    // both read ports combinational
    assign rd_data = (mem_sel && !(|per_we)) ? mem[mem_idx] : '0;
    assign hw_data = mem[hw_idx[aw-1:0]];

endmodule

/* acfa_meta_regs.sv */
`timescale 1ns/1ps
`include "acfa_config.svh"

module acfa_meta_regs (
    input  logic                    mclk,
    input  logic                    puc_rst,
    input  logic                    per_en,
    input  logic [13:0]             per_addr,
    input  logic [1:0]              per_we,
    input  logic [15:0]             per_din,
    input  logic                    entered_tcb,        // inside the trusted code
    input  logic                    cm_uart_continue,   // log is being sent
    input  logic [15:0]             cflow_logs_ptr_din,
    input  logic [15:0]             top_slice,
    input  logic [15:0]             bottom_slice,
    input  logic                    flush_log,
    input  logic                    flush_slice,
    input  logic                    er_done,
    input  logic                    full_level,         // response buffer full
    input  acfa_map_pkg::meta_reg_e hw_idx,
    output logic [15:0]             rd_data,
    output logic [15:0]             hw_data,
    output logic [15:0]             er_min,
    output logic [15:0]             er_max,
    output logic [15:0]             log_state_out,
    output logic [15:0]             vrf_response_out
);
    import acfa_map_pkg::*;
    import acfa_status_pkg::*;

    // ------------------------------------------------------------
    // address decode
    // ------------------------------------------------------------
    logic        reg_sel;
    logic [13:0] reg_off;
    meta_reg_e   reg_idx;
    logic        reg_wr;
    logic        reg_rd;

    assign reg_sel = per_en && (per_addr >= `ACFA_META_BASE)
                     && (per_addr < `ACFA_META_BASE + `ACFA_META_WORDS);
    assign reg_off = per_addr - `ACFA_META_BASE;
    assign reg_idx = meta_reg_e'(reg_off[2:0]);
    assign reg_wr  = reg_sel && (|per_we);   // whole word, no byte lanes
    assign reg_rd  = reg_sel && !(|per_we);

    // ------------------------------------------------------------
    // registers
    // ------------------------------------------------------------
    logic [15:0] er_min_q, er_max_q, log_ptr_q;
    logic [15:0] top_slice_q, bottom_slice_q;
    logic [15:0] log_state_q, vrf_response_q;

    always_ff @(posedge mclk or posedge puc_rst)
    begin
        if (puc_rst)
        begin
            er_min_q       <= '0;
            er_max_q       <= '0;
            log_ptr_q      <= '0;
            top_slice_q    <= `ACFA_TOP_SLICE_RST;
            bottom_slice_q <= `ACFA_BOTTOM_SLICE_RST;
            log_state_q    <= LOG_RESET;
            vrf_response_q <= RESP_RESET;
        end
        else
        begin
            if (reg_wr && reg_idx == REG_ERMIN) er_min_q <= per_din;
            if (reg_wr && reg_idx == REG_ERMAX) er_max_q <= per_din;
            if (entered_tcb && !cm_uart_continue)
                log_ptr_q <= cflow_logs_ptr_din;    // frozen while sending
            top_slice_q    <= top_slice;            // plain copy each cycle
            bottom_slice_q <= bottom_slice;
            // report cause, both flushes win
            if (flush_log && flush_slice)   log_state_q <= LOG_FULL_SLICE;
            else if (flush_log)             log_state_q <= LOG_FULL;
            else if (flush_slice || er_done) log_state_q <= LOG_SLICE_DONE;
            // trusted code may overwrite, a new report clears
            if (reg_wr && reg_idx == REG_VRF_RESPONSE) vrf_response_q <= per_din;
            else if (flush_log || flush_slice)        vrf_response_q <= RESP_CLEAR;
            else if (full_level)                      vrf_response_q <= RESP_RECEIVED;
        end
    end

    // ------------------------------------------------------------
    // read out, same mux for bus and transmit port
    // ------------------------------------------------------------
    function automatic logic [15:0] reg_value(input meta_reg_e idx);
        case (idx)
            REG_ERMIN:        return er_min_q;
            REG_ERMAX:        return er_max_q;
            REG_LOG_PTR:      return log_ptr_q;
            REG_TOP_SLICE:    return top_slice_q;
            REG_BOTTOM_SLICE: return bottom_slice_q;
            REG_LOG_STATE:    return log_state_q;
            REG_VRF_RESPONSE: return vrf_response_q;
            default:          return '0;   // hole at index 7
        endcase
    endfunction

    assign rd_data          = reg_rd ? reg_value(reg_idx) : '0;
    assign hw_data          = reg_value(hw_idx);
    assign er_min           = er_min_q;
    assign er_max           = er_max_q;
    assign log_state_out    = log_state_q;
    assign vrf_response_out = vrf_response_q;

    // log_state only ever carries a defined code
    a_log_state_legal: assert property (@(posedge mclk) disable iff (puc_rst)
        log_state_q inside {LOG_RESET, LOG_SLICE_DONE, LOG_FULL, LOG_FULL_SLICE});

endmodule

/* acfa_status_pkg.sv */
package acfa_status_pkg;

    // log state codes, reported to the verifier
    typedef enum logic [15:0] {
        LOG_RESET      = 16'h00CC,  // no report yet
        LOG_SLICE_DONE = 16'h0001,  // slice flushed or er finished
        LOG_FULL       = 16'h0002,  // log memory filled up
        LOG_FULL_SLICE = 16'h0003   // both at once
    } log_state_e;

    // verifier response codes
    typedef enum logic [15:0] {
        RESP_RESET    = 16'h00DD,  // nothing seen since reset
        RESP_CLEAR    = 16'h0000,  // waiting on the verifier
        RESP_RECEIVED = 16'h0001   // response buffer filled
    } vrf_resp_e;

endpackage

/* acfa_map_pkg.sv */
package acfa_map_pkg;

`include "acfa_config.svh"

    // ------------------------------------------------------------
    // metadata registers, in address order
    // ------------------------------------------------------------
    typedef enum logic [2:0] {
        REG_ERMIN        = 3'd0,  // executable region start
        REG_ERMAX        = 3'd1,  // executable region end
        REG_LOG_PTR      = 3'd2,  // control flow log pointer
        REG_TOP_SLICE    = 3'd3,
        REG_BOTTOM_SLICE = 3'd4,
        REG_LOG_STATE    = 3'd5,  // why the report was started
        REG_VRF_RESPONSE = 3'd6   // verifier answered
    } meta_reg_e;

    // report image regions, in transmit order
    typedef enum logic [1:0] {
        TX_MAC,
        TX_CHAL,
        TX_META,
        TX_NONE   // past the end of the image
    } tx_region_e;

    // region start indices within the report image
    localparam logic [15:0] TX_CHAL_START = 16'(`ACFA_MAC_WORDS);
    localparam logic [15:0] TX_META_START = 16'(`ACFA_MAC_WORDS + `ACFA_CHAL_WORDS);
    localparam logic [15:0] TX_END =
        16'(`ACFA_MAC_WORDS + `ACFA_CHAL_WORDS + `ACFA_META_WORDS);

endpackage

/* acfa_config.svh */
`ifndef ACFA_CONFIG_SVH
`define ACFA_CONFIG_SVH

// ------------------------------------------------------------
// peripheral address map, word addresses (byte address >> 1)
// ------------------------------------------------------------
`define ACFA_CHAL_BASE        14'h0C0   // challenge, byte 0x180
`define ACFA_META_BASE        14'h0D0   // metadata registers, byte 0x1a0
`define ACFA_MAC_BASE         14'h0D7   // mac, byte 0x1ae
`define ACFA_VRF_BASE         14'h0E8   // verifier response, byte 0x1d0

// region sizes
`define ACFA_CHAL_WORDS       16        // 256 bit challenge
`define ACFA_MAC_WORDS        16        // 256 bit mac
`define ACFA_META_WORDS       7         // ermin .. vrf_response
`define ACFA_VRF_BYTES        66        // full verifier response

// ------------------------------------------------------------
// status register reset values
// ------------------------------------------------------------
// recognisable patterns, visible before the slice monitor runs
`define ACFA_TOP_SLICE_RST    16'h00AA
`define ACFA_BOTTOM_SLICE_RST 16'h00BB

`endif
